/* files.f */
+incdir+rtl
rtl/ctrl_pkg.sv
rtl/decode.sv
rtl/rename_table.sv
rtl/freelist.sv
rtl/rename.sv
rtl/rob.sv
rtl/ctrlblock.sv
testbench/ctrlblock_sva.sv
testbench/ctrlblock_checker.sv
testbench/ctrlblock_tb.sv

/* Makefile */
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f files.f --top-module ctrlblock_tb

sim:
	verilator --binary --timing --assert -f files.f --top-module ctrlblock_tb
	@out=$$(./obj_dir/Vctrlblock_tb); echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir

/* testbench/ctrlblock_tb.sv */
`timescale 1ns/1ps
`include "ctrl_config.svh"

module ctrlblock_tb import ctrl_pkg::*; ();

    localparam int N_FIRST = 60;
    localparam int N_STALL = 40;
    localparam int N_LAST  = 60;
    localparam int N_TOTAL = N_FIRST + N_STALL + N_LAST;

    logic    clock;
    logic    reset;
    logic    fetch_valid;
    fetch_t  fetch;
    logic    fetch_ready;
    logic    issue_valid;
    issue_t  issue;
    logic    issue_ready;
    wb_t     writeback;
    logic    commit_valid;
    commit_t commit;

    integer   seed = 89435;
    logic     wb_enable;
    logic     exp_valid;
    issue_t   exp_issue;
    logic     run_done;
    logic     report_done;
    int       mismatches;
    int       missing;
    int       other_errors;
    int       accepted;
    int       committed;
    int       acc0;
    int       acc1;
    int       acc2;
    int       idx;
    issue_t   model_out;
    issue_t   retired;
    logic [63:0] next_pc;

    // Reference state
    preg_t    model_map [`LREG_NUM];
    preg_t    model_free [$];
    rob_tag_t model_tag;
    issue_t   in_flight [$];
    rob_tag_t issued_tags [$];
    rob_tag_t wb_pool [$];

    ctrlblock uut (
        .clock       (clock),
        .reset       (reset),
        .fetch_valid (fetch_valid),
        .fetch       (fetch),
        .fetch_ready (fetch_ready),
        .issue_valid (issue_valid),
        .issue       (issue),
        .issue_ready (issue_ready),
        .writeback   (writeback),
        .commit_valid(commit_valid),
        .commit      (commit)
    );

    ctrlblock_checker u_checker (
        .clock       (clock),
        .reset       (reset),
        .exp_valid   (exp_valid),
        .exp_issue   (exp_issue),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready),
        .issue       (issue),
        .commit_valid(commit_valid),
        .commit      (commit),
        .run_done    (run_done),
        .mismatches  (mismatches),
        .missing     (missing),
        .report_done (report_done)
    );

    bind ctrlblock ctrlblock_sva u_sva (
        .clock       (clock),
        .reset       (reset),
        .fetch_valid (fetch_valid),
        .fetch       (fetch),
        .fetch_ready (fetch_ready),
        .issue_valid (issue_valid),
        .issue       (issue),
        .issue_ready (issue_ready),
        .commit_valid(commit_valid)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // Expected issue of one accepted instruction from the decode rules and the model state
    function automatic issue_t rename_model(fetch_t f);
        issue_t   e;
        decoded_t d;
        d       = '0;
        d.pc    = f.pc;
        d.instr = f.instr;
        case (f.instr.r.opcode)
            7'b0110011: begin
                d.src1_is_reg = 1'b1;
                d.src2_is_reg = 1'b1;
                d.lrs1        = f.instr.r.rs1;
                d.lrs2        = f.instr.r.rs2;
                d.lrd         = f.instr.r.rd;
            end
            7'b0010011, 7'b0000011: begin
                d.src1_is_reg = 1'b1;
                d.lrs1        = f.instr.i.rs1;
                d.lrd         = f.instr.i.rd;
                d.imm         = 64'($signed(f.instr.i.imm12));
            end
            default: begin
            end
        endcase
        d.need_to_wb = (d.lrd != 0);
        e          = '0;
        e.ren.dec  = d;
        e.ren.prs1 = d.src1_is_reg ? model_map[d.lrs1] : '0;
        e.ren.prs2 = d.src2_is_reg ? model_map[d.lrs2] : '0;
        if (d.need_to_wb) begin
            e.ren.prd        = model_free.pop_front();
            e.ren.old_prd    = model_map[d.lrd];
            model_map[d.lrd] = e.ren.prd;
        end
        e.tag     = model_tag;
        model_tag = model_tag + (`ROB_W+1)'(1);
        return e;
    endfunction

    always @(posedge clock) begin
        if (!reset) begin
            exp_valid <= 1'b0;
            if (fetch_valid && fetch_ready) begin
                model_out = rename_model(fetch);
                exp_valid <= 1'b1;
                exp_issue <= model_out;
                in_flight.push_back(model_out);
                issued_tags.push_back(model_out.tag);
                accepted++;
            end
            if (commit_valid && in_flight.size() > 0) begin
                retired = in_flight.pop_front();
                if (retired.ren.dec.need_to_wb) begin
                    model_free.push_back(retired.ren.old_prd); // Freed after the alloc above
                end
                committed++;
            end
            if (issue_valid && issue_ready && issued_tags.size() > 0) begin
                wb_pool.push_back(issued_tags.pop_front());
            end
            writeback <= '0;
            if (wb_enable && wb_pool.size() > 0 && ($random(seed) & 1)) begin
                idx = $unsigned($random(seed)) % wb_pool.size(); // Random completion order
                writeback <= {1'b1, wb_pool[idx]};
                wb_pool.delete(idx);
            end
        end
    end

    always @(posedge clock) begin
        if (reset) begin
            issue_ready <= 1'b0;
        end else begin
            issue_ready <= ($random(seed) & 3) != 0;
        end
    end

    task automatic send_instr(input logic need_dest);
        fetch_t     f;
        logic [2:0] kind;
        f.instr = $random(seed);
        f.pc    = next_pc;
        next_pc = next_pc + 64'd4;
        kind    = 3'($random(seed));
        case (kind)
            3'd0, 3'd1, 3'd2: f.instr.r.opcode = 7'b0110011;
            3'd3, 3'd4:       f.instr.r.opcode = 7'b0010011;
            3'd5:             f.instr.r.opcode = 7'b0000011;
            default:          f.instr.r.opcode = 7'b1100011;
        endcase
        if (kind == 3'd2) begin
            f.instr.r.rd = '0;
        end
        if (need_dest) begin
            f.instr.r.opcode = 7'b0010011;
            f.instr.r.rd     = f.instr.r.rd | 5'd1;
        end
        fetch_valid <= 1'b1;
        fetch       <= f;
        do @(posedge clock); while (!fetch_ready);
        fetch_valid <= 1'b0;
        if (($random(seed) & 3) == 0) begin
            @(posedge clock);
        end
    endtask

    task automatic drain();
        do @(negedge clock); while (committed != accepted);
        @(posedge clock);
    endtask

    initial begin
        reset        = 1'b1;
        fetch_valid  = 1'b0;
        fetch        = '0;
        issue_ready  = 1'b0;
        writeback    = '0;
        wb_enable    = 1'b1;
        exp_valid    = 1'b0;
        exp_issue    = '0;
        run_done     = 1'b0;
        other_errors = 0;
        accepted     = 0;
        committed    = 0;
        next_pc      = 64'h8000_0000;
        model_tag    = '0;
        for (int i = 0; i < `LREG_NUM; i++) begin
            model_map[i] = preg_t'(i);
            model_free.push_back(preg_t'(`LREG_NUM + i));
        end
        repeat (4) @(posedge clock);
        reset <= 1'b0;
        @(posedge clock);
        for (int i = 0; i < N_FIRST; i++) begin
            send_instr(1'b0);
        end
        drain();
        acc0 = accepted;
        wb_enable <= 1'b0;
        fork
            begin
                for (int i = 0; i < N_STALL; i++) begin
                    send_instr(1'b1);
                end
            end
            begin
                repeat (60) @(posedge clock);
                acc1 = accepted;
                repeat (20) @(posedge clock);
                acc2 = accepted;
                if (acc2 != acc1 || acc1 - acc0 > 16) begin
                    $display("fetch kept flowing with no writeback (%0d then %0d accepted)",
                             acc1 - acc0, acc2 - acc0);
                    other_errors++;
                end
                wb_enable <= 1'b1;
            end
        join
        for (int i = 0; i < N_LAST; i++) begin
            send_instr(1'b0);
        end
        drain();
        run_done <= 1'b1;
        while (!report_done) begin
            @(posedge clock);
        end
        $display("errors: %0d mismatches, %0d missing, %0d other", mismatches, missing,
                 other_errors);
        if (mismatches + missing + other_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        #(N_TOTAL * 20 * 4);
        $display("timeout: run did not finish within %0d cycles", N_TOTAL * 20);
        $display("sim failed");
        $finish;
    end

endmodule

/* testbench/ctrlblock_checker.sv */
`timescale 1ns/1ps
`include "ctrl_config.svh"

module ctrlblock_checker import ctrl_pkg::*; (
    input  logic    clock,
    input  logic    reset,
    input  logic    exp_valid,
    input  issue_t  exp_issue,
    input  logic    issue_valid,
    input  logic    issue_ready,
    input  issue_t  issue,
    input  logic    commit_valid,
    input  commit_t commit,
    input  logic    run_done,
    output int      mismatches,
    output int      missing,
    output logic    report_done
);

    issue_t  exp_q [$];
    commit_t cmt_q [$];
    issue_t  want;
    commit_t want_c;

    task automatic compare_value(input string name, input logic [255:0] got,
                                 input logic [255:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
            mismatches++;
        end
    endtask

    always @(posedge clock) begin
        if (reset) begin
            mismatches  = 0;
            missing     = 0;
            report_done = 1'b0;
            exp_q.delete();
            cmt_q.delete();
        end else begin
            if (exp_valid) begin
                exp_q.push_back(exp_issue); // Pushed ahead of the pop as both can fall on one edge
            end
            if (issue_valid && issue_ready) begin
                if (exp_q.size() == 0) begin
                    $display("issue transfer at %0t with no instruction expected", $time);
                    missing++;
                end else begin
                    want = exp_q.pop_front();
                    compare_value("issue.dec", 256'(issue.ren.dec), 256'(want.ren.dec));
                    compare_value("issue.prs1", 256'(issue.ren.prs1), 256'(want.ren.prs1));
                    compare_value("issue.prs2", 256'(issue.ren.prs2), 256'(want.ren.prs2));
                    compare_value("issue.prd", 256'(issue.ren.prd), 256'(want.ren.prd));
                    compare_value("issue.old_prd", 256'(issue.ren.old_prd),
                                  256'(want.ren.old_prd));
                    compare_value("issue.tag", 256'(issue.tag), 256'(want.tag));
                    want_c.lrd        = want.ren.dec.lrd;
                    want_c.prd        = want.ren.prd;
                    want_c.old_prd    = want.ren.old_prd;
                    want_c.need_to_wb = want.ren.dec.need_to_wb;
                    want_c.pc         = want.ren.dec.pc;
                    cmt_q.push_back(want_c);
                end
            end
            if (commit_valid) begin
                if (cmt_q.size() == 0) begin
                    $display("commit at %0t with nothing issued", $time);
                    missing++;
                end else begin
                    want_c = cmt_q.pop_front();
                    compare_value("commit.lrd", 256'(commit.lrd), 256'(want_c.lrd));
                    compare_value("commit.prd", 256'(commit.prd), 256'(want_c.prd));
                    compare_value("commit.old_prd", 256'(commit.old_prd),
                                  256'(want_c.old_prd));
                    compare_value("commit.need_to_wb", 256'(commit.need_to_wb),
                                  256'(want_c.need_to_wb));
                    compare_value("commit.pc", 256'(commit.pc), 256'(want_c.pc));
                end
            end
            if (run_done && !report_done) begin
                if (exp_q.size() != 0) begin
                    $display("%0d instructions never reached issue", exp_q.size());
                    missing += exp_q.size();
                end
                if (cmt_q.size() != 0) begin
                    $display("%0d issued instructions never committed", cmt_q.size());
                    missing += cmt_q.size();
                end
                report_done = 1'b1;
            end
        end
    end

endmodule

/* testbench/ctrlblock_sva.sv */
`timescale 1ns/1ps

module ctrlblock_sva import ctrl_pkg::*; (
    input logic   clock,
    input logic   reset,
    input logic   fetch_valid,
    input fetch_t fetch,
    input logic   fetch_ready,
    input logic   issue_valid,
    input issue_t issue,
    input logic   issue_ready,
    input logic   commit_valid
);

    // Held issue must not change or drop
    issue_hold: assert property (@(posedge clock) disable iff (reset)
        issue_valid && !issue_ready |=> issue_valid && $stable(issue))
        else $error("issue changed while stalled");

    fetch_hold: assert property (@(posedge clock) disable iff (reset)
        fetch_valid && !fetch_ready |=> fetch_valid && $stable(fetch))
        else $error("fetch changed while stalled");

    reset_idle: assert property (@(posedge clock)
        reset |=> !issue_valid && !commit_valid)
        else $error("valid high after reset");

endmodule

/* rtl/ctrlblock.sv */
`timescale 1ns/1ps
`include "ctrl_config.svh"

module ctrlblock
    import ctrl_pkg::*;
(
    input  logic    clock,
    input  logic    reset,
    input  logic    fetch_valid,
    input  fetch_t  fetch,
    output logic    fetch_ready,
    output logic    issue_valid,
    output issue_t  issue,
    input  logic    issue_ready,
    input  wb_t     writeback,
    output logic    commit_valid,
    output commit_t commit
);

    decoded_t dec;
    preg_t    rat_prs1;
    preg_t    rat_prs2;
    preg_t    rat_old_prd;
    logic     rat_write_valid;
    lreg_t    rat_write_lreg;
    preg_t    rat_write_preg;
    logic     alloc_valid;
    preg_t    alloc_preg;
    logic     freelist_empty;
    logic     release_valid;
    preg_t    release_preg;
    rob_tag_t rob_tag;
    logic     rob_full;
    wire      issue_fire = issue_valid & issue_ready; // ROB enqueue on issue transfer

    decode u_decode (
        .instr(fetch.instr),
        .pc   (fetch.pc),
        .dec  (dec)
    );

    rename_table u_rename_table (
        .clock      (clock),
        .reset      (reset),
        .lrs1       (dec.lrs1),
        .lrs2       (dec.lrs2),
        .lrd        (dec.lrd),
        .prs1       (rat_prs1),
        .prs2       (rat_prs2),
        .old_prd    (rat_old_prd),
        .write_valid(rat_write_valid),
        .write_lreg (rat_write_lreg),
        .write_preg (rat_write_preg)
    );

    freelist u_freelist (
        .clock        (clock),
        .reset        (reset),
        .alloc_valid  (alloc_valid),
        .alloc_preg   (alloc_preg),
        .empty        (freelist_empty),
        .release_valid(release_valid),
        .release_preg (release_preg)
    );

    rename u_rename (
        .clock            (clock),
        .reset            (reset),
        .in_valid         (fetch_valid),
        .in_ready         (fetch_ready),
        .dec              (dec),
        .table_prs1       (rat_prs1),
        .table_prs2       (rat_prs2),
        .table_old_prd    (rat_old_prd),
        .table_write_valid(rat_write_valid),
        .table_write_lreg (rat_write_lreg),
        .table_write_preg (rat_write_preg),
        .alloc_valid      (alloc_valid),
        .alloc_preg       (alloc_preg),
        .freelist_empty   (freelist_empty),
        .rob_full         (rob_full),
        .rob_tag          (rob_tag),
        .issue_valid      (issue_valid),
        .issue            (issue),
        .issue_ready      (issue_ready)
    );

    rob u_rob (
        .clock        (clock),
        .reset        (reset),
        .enq_valid    (issue_fire),
        .enq          (issue),
        .enq_tag      (rob_tag),
        .full         (rob_full),
        .writeback    (writeback),
        .commit_valid (commit_valid),
        .commit       (commit),
        .release_valid(release_valid),
        .release_preg (release_preg)
    );

endmodule

/* rtl/rob.sv */
`timescale 1ns/1ps
`include "ctrl_config.svh"

module rob
    import ctrl_pkg::*;
(
    input  logic     clock,
    input  logic     reset,
    input  logic     enq_valid,
    input  issue_t   enq,
    output rob_tag_t enq_tag,
    output logic     full,
    input  wb_t      writeback,
    output logic     commit_valid,
    output commit_t  commit,
    output logic     release_valid,
    output preg_t    release_preg
);

    localparam int TW = `ROB_W + 1;

    commit_t              entries [`ROB_SIZE];
    logic [`ROB_SIZE-1:0] done;
    rob_tag_t             head;
    rob_tag_t             tail;
    logic [TW-1:0]        used;
    logic                 retire;
    commit_t              enq_entry;

    assign enq_tag = tail;
    assign used    = tail - head;
    // One slot stays back for the instruction parked in rename
    assign full    = (used >= TW'(`ROB_SIZE - 1));
    assign retire  = (head != tail) && done[head.idx];

    always_comb begin
        enq_entry.lrd        = enq.ren.dec.lrd;
        enq_entry.prd        = enq.ren.prd;
        enq_entry.old_prd    = enq.ren.old_prd;
        enq_entry.need_to_wb = enq.ren.dec.need_to_wb;
        enq_entry.pc         = enq.ren.dec.pc;
    end

    always_ff @(posedge clock) begin
        if (enq_valid) begin
            entries[tail.idx] <= enq_entry;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head <= '0;
            tail <= '0;
            done <= '0;
        end else begin
            if (enq_valid) begin
                done[tail.idx] <= 1'b0;
                tail           <= tail + TW'(1);
            end
            if (writeback.valid) begin
                done[writeback.tag.idx] <= 1'b1; // Completion may come in any order
            end
            if (retire) begin
                done[head.idx] <= 1'b0;
                head           <= head + TW'(1);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            commit_valid <= 1'b0;
        end else begin
            commit_valid <= retire;
        end
    end

    always_ff @(posedge clock) begin
        if (retire) begin
            commit <= entries[head.idx];
        end
    end

    assign release_valid = commit_valid && commit.need_to_wb; // Old mapping is dead now
    assign release_preg  = commit.old_prd;

endmodule

/* rtl/rename.sv */
`timescale 1ns/1ps
`include "ctrl_config.svh"

module rename
    import ctrl_pkg::*;
(
    input  logic     clock,
    input  logic     reset,
    input  logic     in_valid,
    output logic     in_ready,
    input  decoded_t dec,
    input  preg_t    table_prs1,
    input  preg_t    table_prs2,
    input  preg_t    table_old_prd,
    output logic     table_write_valid,
    output lreg_t    table_write_lreg,
    output preg_t    table_write_preg,
    output logic     alloc_valid,
    input  preg_t    alloc_preg,
    input  logic     freelist_empty,
    input  logic     rob_full,
    input  rob_tag_t rob_tag,
    output logic     issue_valid,
    output issue_t   issue,
    input  logic     issue_ready
);

    logic     stall;
    logic     fire;
    rob_tag_t tag_after_held;

    assign stall    = (dec.need_to_wb && freelist_empty) || rob_full;
    assign in_ready = (!issue_valid || issue_ready) && !stall;
    assign fire     = in_valid && in_ready;

    assign alloc_valid       = fire && dec.need_to_wb;
    assign table_write_valid = alloc_valid;
    assign table_write_lreg  = dec.lrd;
    assign table_write_preg  = alloc_preg;

    // The held entry owns rob_tag until it enqueues, so the next one gets the tag after it
    assign tag_after_held = rob_tag + (`ROB_W+1)'(1);

    always_ff @(posedge clock) begin
        if (reset) begin
            issue_valid <= 1'b0;
        end else if (fire) begin
            issue_valid <= 1'b1;
        end else if (issue_ready) begin
            issue_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (fire) begin
            issue.ren.dec     <= dec;
            issue.ren.prs1    <= table_prs1;
            issue.ren.prs2    <= table_prs2;
            issue.ren.prd     <= dec.need_to_wb ? alloc_preg : '0;
            issue.ren.old_prd <= dec.need_to_wb ? table_old_prd : '0;
            issue.tag         <= issue_valid ? tag_after_held : rob_tag;
        end
    end

endmodule

/* rtl/freelist.sv */
`timescale 1ns/1ps
`include "ctrl_config.svh"

module freelist
    import ctrl_pkg::*;
(
    input  logic  clock,
    input  logic  reset,
    input  logic  alloc_valid,
    output preg_t alloc_preg,
    output logic  empty,
    input  logic  release_valid,
    input  preg_t release_preg
);

    localparam int FL_SIZE = `PREG_NUM - `LREG_NUM;
    localparam int FL_W    = $clog2(FL_SIZE);

    preg_t           slots [FL_SIZE];
    logic [FL_W-1:0] head;
    logic [FL_W-1:0] tail;
    logic [FL_W:0]   count;

    assign alloc_preg = slots[head];
    assign empty      = (count == '0);

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < FL_SIZE; i++) begin
                slots[i] <= preg_t'(`LREG_NUM + i); // Upper half starts free
            end
            head  <= '0;
            tail  <= '0;
            count <= (FL_W+1)'(FL_SIZE);
        end else begin
            if (release_valid) begin
                slots[tail] <= release_preg;
                tail        <= tail + FL_W'(1);
            end
            if (alloc_valid) begin
                head <= head + FL_W'(1);
            end
            count <= count + (FL_W+1)'(release_valid) - (FL_W+1)'(alloc_valid);
        end
    end

endmodule

/* rtl/rename_table.sv */
`timescale 1ns/1ps
`include "ctrl_config.svh"

module rename_table
    import ctrl_pkg::*;
(
    input  logic  clock,
    input  logic  reset,
    input  lreg_t lrs1,
    input  lreg_t lrs2,
    input  lreg_t lrd,
    output preg_t prs1,
    output preg_t prs2,
    output preg_t old_prd,
    input  logic  write_valid,
    input  lreg_t write_lreg,
    input  preg_t write_preg
);

    preg_t map [`LREG_NUM];

    // Unused source fields arrive as x0, which maps to physical 0
    assign prs1    = map[lrs1];
    assign prs2    = map[lrs2];
    assign old_prd = map[lrd];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `LREG_NUM; i++) begin
                map[i] <= preg_t'(i); // Identity map
            end
        end else if (write_valid && write_lreg != '0) begin
            map[write_lreg] <= write_preg;
        end
    end

endmodule

/* rtl/decode.sv */
`timescale 1ns/1ps
`include "ctrl_config.svh"

module decode
    import ctrl_pkg::*;
(
    input  instr_word_t      instr,
    input  logic [`PC_W-1:0] pc,
    output decoded_t         dec
);

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;

    always_comb begin
        dec       = '0;
        dec.pc    = pc;
        dec.instr = instr;
        case (instr.r.opcode)
            OPC_OP: begin
                dec.src1_is_reg = 1'b1;
                dec.src2_is_reg = 1'b1;
                dec.lrs1        = instr.r.rs1;
                dec.lrs2        = instr.r.rs2;
                dec.lrd         = instr.r.rd;
            end
            OPC_OP_IMM, OPC_LOAD: begin
                dec.src1_is_reg = 1'b1;
                dec.lrs1        = instr.i.rs1;
                dec.lrd         = instr.i.rd;
                dec.imm         = {{(`XLEN-12){instr.i.imm12[11]}}, instr.i.imm12};
            end
            default: begin
            end
        endcase
        dec.need_to_wb = (dec.lrd != '0); // x0 never gets a new register
    end

endmodule

/* rtl/ctrl_pkg.sv */
`include "ctrl_config.svh"

package ctrl_pkg;

    typedef logic [`LREG_W-1:0] lreg_t;
    typedef logic [`PREG_W-1:0] preg_t;

    // Same 32 bits, read as R-format or I-format
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            lreg_t      rs2;
            lreg_t      rs1;
            logic [2:0] funct3;
            lreg_t      rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm12;
            lreg_t       rs1;
            logic [2:0]  funct3;
            lreg_t       rd;
            logic [6:0]  opcode;
        } i;
    } instr_word_t;

    typedef struct packed {
        instr_word_t          instr;
        logic [`PC_W-1:0]     pc;
    } fetch_t;

    typedef struct packed {
        lreg_t                lrs1;
        lreg_t                lrs2;
        lreg_t                lrd;
        logic                 src1_is_reg;
        logic                 src2_is_reg;
        logic                 need_to_wb;
        logic [`XLEN-1:0]     imm;
        logic [`PC_W-1:0]     pc;
        instr_word_t          instr;
    } decoded_t;

    typedef struct packed {
        logic                 flag;    // Flips on each pass around the ROB
        logic [`ROB_W-1:0]    idx;
    } rob_tag_t;

    typedef struct packed {
        decoded_t             dec;
        preg_t                prs1;
        preg_t                prs2;
        preg_t                prd;
        preg_t                old_prd;
    } renamed_t;

    typedef struct packed {
        renamed_t             ren;
        rob_tag_t             tag;
    } issue_t;

    typedef struct packed {
        logic                 valid;
        rob_tag_t             tag;
    } wb_t;

    typedef struct packed {
        lreg_t                lrd;
        preg_t                prd;
        preg_t                old_prd;
        logic                 need_to_wb;
        logic [`PC_W-1:0]     pc;
    } commit_t;

endpackage

/* rtl/ctrl_config.svh */
`ifndef CTRL_CONFIG_SVH
`define CTRL_CONFIG_SVH

// Register files
`define LREG_NUM 32
`define PREG_NUM 64
`define LREG_W   5
`define PREG_W   6

// Reorder buffer
`define ROB_SIZE 16
`define ROB_W    4

// Datapath
`define XLEN 64
`define PC_W 64

`endif
